// ==== design/board_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_regs (
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  logic [wb_core_pkg::wb_aw-1:0] adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] dat_i,
   input  logic                          we_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   output logic [wb_core_pkg::wb_dw-1:0] dat_o,
   output logic                          ack_o,
   input  logic [7:0]                    switch_i,
   input  logic [2:0]                    button_i,
   output logic [2:0]                    led_o,
   output logic [3:0]                    flags_o
);

   import wb_core_pkg::*;

   logic [wb_dw-1:0] fast_r;
   logic [3:0]       flags_r;
   logic [6:0]       offset;
   logic             wr_en;

   assign offset = adr_i[6:0];
   assign wr_en  = cyc_i & stb_i & we_i;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         fast_r  <= '0;
         flags_r <= '0;
      end else if (wr_en) begin
         if (offset == reg_fast) fast_r <= dat_i;
         if (offset == reg_flags) flags_r <= dat_i[3:0];
      end
   end

   // Readback, unknown offsets give a recognisable pattern
   always_comb begin
      case (offset)
         reg_fast:     dat_o = fast_r;
         reg_switches: dat_o = {5'b0, button_i, switch_i};
         default:      dat_o = bad_read_value;
      endcase
   end

   assign ack_o   = cyc_i & stb_i;
   assign led_o   = fast_r[2:0];
   assign flags_o = flags_r;

endmodule

`default_nettype wire

// ==== design/gpio16.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio16 #(
   parameter int gpio_w = 16
) (
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  logic [wb_core_pkg::wb_aw-1:0] adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] dat_i,
   input  logic                          we_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   output logic [wb_core_pkg::wb_dw-1:0] dat_o,
   output logic                          ack_o,
   input  logic [gpio_w-1:0]             gpio_i,
   output logic [gpio_w-1:0]             gpio_o,
   output logic [gpio_w-1:0]             gpio_oe_o
);

   import wb_core_pkg::*;

   logic [gpio_w-1:0] ddr_r;
   logic [gpio_w-1:0] out_r;
   logic [gpio_w-1:0] sync1;
   logic [gpio_w-1:0] sync2;
   logic [3:0]        offset;
   logic              wr_en;

   assign offset = adr_i[3:0];
   assign wr_en  = cyc_i & stb_i & we_i;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         ddr_r <= '0;
         out_r <= '0;
      end else if (wr_en) begin
         if (offset == gpio_ddr) ddr_r <= dat_i[gpio_w-1:0];
         if (offset == gpio_out) out_r <= dat_i[gpio_w-1:0];
      end
   end

   // Pins are asynchronous, two flops before the bus sees them
   always_ff @(posedge wb_clk) begin
      sync1 <= gpio_i;
      sync2 <= sync1;
   end

   always_comb begin
      case (offset)
         gpio_ddr: dat_o = wb_dw'(ddr_r);
         gpio_out: dat_o = wb_dw'(out_r);
         gpio_in:  dat_o = wb_dw'(sync2);
         default:  dat_o = '0;
      endcase
   end

   assign ack_o     = cyc_i & stb_i;
   assign gpio_o    = out_r;
   assign gpio_oe_o = ddr_r;

endmodule

`default_nettype wire

// ==== design/settings_bus_16le.sv ====
`timescale 1ns/1ps
`default_nettype none

module settings_bus_16le (
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  logic [wb_core_pkg::wb_aw-1:0] adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] dat_i,
   input  logic                          we_i,
   input  logic                          cyc_i,
   input  logic                          stb_i,
   output logic                          ack_o,
   output logic                          set_stb_o,
   output logic [7:0]                    set_addr_o,
   output wb_core_pkg::set_word_t        set_data_o
);

   import wb_core_pkg::*;

   logic [wb_dw-1:0] lo_r;
   logic             wr_lo;
   logic             wr_hi;

   // Address bit 1 picks the half, low half goes first
   assign wr_lo = cyc_i & stb_i & we_i & ~adr_i[1];
   assign wr_hi = cyc_i & stb_i & we_i & adr_i[1];

   always_ff @(posedge wb_clk) begin
      if (wr_lo) begin
         lo_r <= dat_i;
      end
   end

   // High half completes the word
   always_ff @(posedge wb_clk) begin
      if (wr_hi) begin
         set_data_o.halves.hi <= dat_i;
         set_data_o.halves.lo <= lo_r;
         set_addr_o           <= adr_i[9:2];
      end
   end

   // Strobe lasts one cycle after each high-half write
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         set_stb_o <= 1'b0;
      end else begin
         set_stb_o <= wr_hi;
      end
   end

   assign ack_o = cyc_i & stb_i;

endmodule

`default_nettype wire

// ==== design/wb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_core #(
   parameter int gpio_w = 16
) (
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   // Host port
   input  logic                          req_valid_i,
   input  logic                          req_we_i,
   input  logic [wb_core_pkg::wb_aw-1:0] req_adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] req_dat_i,
   input  logic [wb_core_pkg::wb_sw-1:0] req_sel_i,
   output logic                          req_ready_o,
   output logic                          rsp_valid_o,
   output logic [wb_core_pkg::wb_dw-1:0] rsp_dat_o,
   output logic                          rsp_err_o,
   input  logic                          rsp_ready_i,
   // Board
   input  logic [7:0]                    switch_i,
   input  logic [2:0]                    button_i,
   output logic [2:0]                    led_o,
   output logic [3:0]                    flags_o,
   // General-purpose pins
   input  logic [gpio_w-1:0]             gpio_i,
   output logic [gpio_w-1:0]             gpio_o,
   output logic [gpio_w-1:0]             gpio_oe_o,
   // Settings
   output logic                          set_stb_o,
   output logic [7:0]                    set_addr_o,
   output wb_core_pkg::set_word_t        set_data_o
);

   import wb_core_pkg::*;

   // Master bus
   logic [wb_aw-1:0] m_adr;
   logic [wb_dw-1:0] m_dat_mosi;
   logic [wb_dw-1:0] m_dat_miso;
   logic [wb_sw-1:0] m_sel;
   logic             m_we, m_cyc, m_stb, m_ack, m_err;

   // Slave side
   logic [wb_aw-1:0] s_adr;
   logic [wb_dw-1:0] s_dat_mosi;
   logic             s_we;
   logic [wb_dw-1:0] s0_dat_miso, s4_dat_miso;
   logic             s0_cyc, s0_stb, s0_ack;
   logic             s4_cyc, s4_stb, s4_ack;
   logic             s5_cyc, s5_stb, s5_ack;

   ////////////////////////////////////////////////////////////////////////////
   // Host request port to Wishbone master

   wb_host_bridge wb_host_bridge_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_valid_i(req_valid_i), .req_we_i(req_we_i), .req_adr_i(req_adr_i),
      .req_dat_i(req_dat_i), .req_sel_i(req_sel_i), .req_ready_o(req_ready_o),
      .rsp_valid_o(rsp_valid_o), .rsp_dat_o(rsp_dat_o), .rsp_err_o(rsp_err_o),
      .rsp_ready_i(rsp_ready_i),
      .wb_adr_o(m_adr), .wb_dat_o(m_dat_mosi), .wb_sel_o(m_sel), .wb_we_o(m_we),
      .wb_cyc_o(m_cyc), .wb_stb_o(m_stb),
      .wb_dat_i(m_dat_miso), .wb_ack_i(m_ack), .wb_err_i(m_err)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Intercon, sixteen slots with three populated

   // No slave uses byte selects, and slot 5 is write-only so it reads zero
   wb_intercon wb_intercon_inst (
      .m_adr_i(m_adr), .m_dat_i(m_dat_mosi), .m_sel_i(m_sel), .m_we_i(m_we),
      .m_cyc_i(m_cyc), .m_stb_i(m_stb),
      .m_dat_o(m_dat_miso), .m_ack_o(m_ack), .m_err_o(m_err),
      .s_adr_o(s_adr), .s_dat_o(s_dat_mosi), .s_sel_o(), .s_we_o(s_we),
      .s0_cyc_o(s0_cyc), .s0_stb_o(s0_stb), .s0_dat_i(s0_dat_miso), .s0_ack_i(s0_ack),
      .s4_cyc_o(s4_cyc), .s4_stb_o(s4_stb), .s4_dat_i(s4_dat_miso), .s4_ack_i(s4_ack),
      .s5_cyc_o(s5_cyc), .s5_stb_o(s5_stb), .s5_dat_i('0), .s5_ack_i(s5_ack)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Slaves

   board_regs board_regs_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(s_adr), .dat_i(s_dat_mosi), .we_i(s_we), .cyc_i(s0_cyc), .stb_i(s0_stb),
      .dat_o(s0_dat_miso), .ack_o(s0_ack),
      .switch_i(switch_i), .button_i(button_i), .led_o(led_o), .flags_o(flags_o)
   );

   gpio16 #(.gpio_w(gpio_w)) gpio16_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(s_adr), .dat_i(s_dat_mosi), .we_i(s_we), .cyc_i(s4_cyc), .stb_i(s4_stb),
      .dat_o(s4_dat_miso), .ack_o(s4_ack),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o)
   );

   settings_bus_16le settings_bus_16le_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(s_adr), .dat_i(s_dat_mosi), .we_i(s_we), .cyc_i(s5_cyc), .stb_i(s5_stb),
      .ack_o(s5_ack),
      .set_stb_o(set_stb_o), .set_addr_o(set_addr_o), .set_data_o(set_data_o)
   );

endmodule

`default_nettype wire

// ==== design/wb_core_pkg.sv ====
`default_nettype none

package wb_core_pkg;

   // Bus geometry
   localparam int wb_dw  = 16;
   localparam int wb_aw  = 11;
   localparam int wb_sw  = 2;
   localparam int slot_w = 4;

   // Slot map, decoded from the top address bits
   localparam logic [slot_w-1:0] slot_board    = 4'd0;
   localparam logic [slot_w-1:0] slot_gpio     = 4'd4;
   localparam logic [slot_w-1:0] slot_settings = 4'd5;

   // Board register offsets in the low seven address bits
   localparam logic [6:0] reg_fast     = 7'd4;
   localparam logic [6:0] reg_switches = 7'd6;
   localparam logic [6:0] reg_flags    = 7'd8;

   // GPIO offsets in the low four address bits
   localparam logic [3:0] gpio_ddr = 4'd0;
   localparam logic [3:0] gpio_out = 4'd2;
   localparam logic [3:0] gpio_in  = 4'd4;

   localparam logic [wb_dw-1:0] bad_read_value = 16'hBEEF;

   // Setting word, built from two bus halves and consumed whole
   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [15:0] hi;
         logic [15:0] lo;
      } halves;
   } set_word_t;

endpackage

`default_nettype wire

// ==== design/wb_host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_host_bridge (
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   // Host request side
   input  logic                          req_valid_i,
   input  logic                          req_we_i,
   input  logic [wb_core_pkg::wb_aw-1:0] req_adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] req_dat_i,
   input  logic [wb_core_pkg::wb_sw-1:0] req_sel_i,
   output logic                          req_ready_o,
   // Host response side
   output logic                          rsp_valid_o,
   output logic [wb_core_pkg::wb_dw-1:0] rsp_dat_o,
   output logic                          rsp_err_o,
   input  logic                          rsp_ready_i,
   // Wishbone master
   output logic [wb_core_pkg::wb_aw-1:0] wb_adr_o,
   output logic [wb_core_pkg::wb_dw-1:0] wb_dat_o,
   output logic [wb_core_pkg::wb_sw-1:0] wb_sel_o,
   output logic                          wb_we_o,
   output logic                          wb_cyc_o,
   output logic                          wb_stb_o,
   input  logic [wb_core_pkg::wb_dw-1:0] wb_dat_i,
   input  logic                          wb_ack_i,
   input  logic                          wb_err_i
);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_bus  = 2'd1;
   localparam logic [1:0] st_rsp  = 2'd2;

   logic [1:0] state;

   // One transaction in flight: idle -> bus -> respond -> idle
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (req_valid_i) state <= st_bus;
            st_bus:  if (wb_ack_i || wb_err_i) state <= st_rsp;
            st_rsp:  if (rsp_ready_i) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // Request held on the bus for the whole cycle
   always_ff @(posedge wb_clk) begin
      if (req_valid_i && req_ready_o) begin
         wb_adr_o <= req_adr_i;
         wb_dat_o <= req_dat_i;
         wb_sel_o <= req_sel_i;
         wb_we_o  <= req_we_i;
      end
   end

   // Capture the answer at the end of the bus cycle, writes return zero
   always_ff @(posedge wb_clk) begin
      if (wb_cyc_o && (wb_ack_i || wb_err_i)) begin
         rsp_dat_o <= wb_we_o ? '0 : wb_dat_i;
         rsp_err_o <= wb_err_i;
      end
   end

   assign req_ready_o = (state == st_idle);
   assign wb_cyc_o    = (state == st_bus);
   assign wb_stb_o    = wb_cyc_o;
   assign rsp_valid_o = (state == st_rsp);

endmodule

`default_nettype wire

// ==== design/wb_intercon.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_intercon (
   // Master side
   input  logic [wb_core_pkg::wb_aw-1:0] m_adr_i,
   input  logic [wb_core_pkg::wb_dw-1:0] m_dat_i,
   input  logic [wb_core_pkg::wb_sw-1:0] m_sel_i,
   input  logic                          m_we_i,
   input  logic                          m_cyc_i,
   input  logic                          m_stb_i,
   output logic [wb_core_pkg::wb_dw-1:0] m_dat_o,
   output logic                          m_ack_o,
   output logic                          m_err_o,
   // Shared slave signals
   output logic [wb_core_pkg::wb_aw-1:0] s_adr_o,
   output logic [wb_core_pkg::wb_dw-1:0] s_dat_o,
   output logic [wb_core_pkg::wb_sw-1:0] s_sel_o,
   output logic                          s_we_o,
   // Slot 0, board registers
   output logic                          s0_cyc_o,
   output logic                          s0_stb_o,
   input  logic [wb_core_pkg::wb_dw-1:0] s0_dat_i,
   input  logic                          s0_ack_i,
   // Slot 4, GPIO
   output logic                          s4_cyc_o,
   output logic                          s4_stb_o,
   input  logic [wb_core_pkg::wb_dw-1:0] s4_dat_i,
   input  logic                          s4_ack_i,
   // Slot 5, settings bus
   output logic                          s5_cyc_o,
   output logic                          s5_stb_o,
   input  logic [wb_core_pkg::wb_dw-1:0] s5_dat_i,
   input  logic                          s5_ack_i
);

   import wb_core_pkg::*;

   logic [slot_w-1:0] slot;
   logic              hit_s0;
   logic              hit_s4;
   logic              hit_s5;

   assign slot   = m_adr_i[wb_aw-1 -: slot_w];
   assign hit_s0 = (slot == slot_board);
   assign hit_s4 = (slot == slot_gpio);
   assign hit_s5 = (slot == slot_settings);

   assign s_adr_o = m_adr_i;
   assign s_dat_o = m_dat_i;
   assign s_sel_o = m_sel_i;
   assign s_we_o  = m_we_i;

   // Only the addressed slave sees the strobe
   assign s0_cyc_o = m_cyc_i & hit_s0;
   assign s0_stb_o = m_stb_i & hit_s0;
   assign s4_cyc_o = m_cyc_i & hit_s4;
   assign s4_stb_o = m_stb_i & hit_s4;
   assign s5_cyc_o = m_cyc_i & hit_s5;
   assign s5_stb_o = m_stb_i & hit_s5;

   always_comb begin
      if (hit_s0) begin
         m_dat_o = s0_dat_i;
      end else if (hit_s4) begin
         m_dat_o = s4_dat_i;
      end else if (hit_s5) begin
         m_dat_o = s5_dat_i;
      end else begin
         m_dat_o = '0;
      end
   end

   assign m_ack_o = (hit_s0 & s0_ack_i) | (hit_s4 & s4_ack_i) | (hit_s5 & s5_ack_i);

   // Empty slots answer at once so the master never hangs
   assign m_err_o = m_cyc_i & m_stb_i & ~(hit_s0 | hit_s4 | hit_s5);

endmodule

`default_nettype wire

// ==== tests/tb_wb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_core;

   import wb_core_pkg::*;

   localparam int gpio_w  = 16;
   localparam int n_col   = 8;
   localparam int max_ops = 32;

   logic              wb_clk;
   logic              wb_rst;
   logic              req_valid_i;
   logic              req_we_i;
   logic [wb_aw-1:0]  req_adr_i;
   logic [wb_dw-1:0]  req_dat_i;
   logic [wb_sw-1:0]  req_sel_i;
   logic              req_ready_o;
   logic              rsp_valid_o;
   logic [wb_dw-1:0]  rsp_dat_o;
   logic              rsp_err_o;
   logic              rsp_ready_i;
   logic [7:0]        switch_i;
   logic [2:0]        button_i;
   logic [2:0]        led_o;
   logic [3:0]        flags_o;
   logic [gpio_w-1:0] gpio_i;
   logic [gpio_w-1:0] gpio_o;
   logic [gpio_w-1:0] gpio_oe_o;
   logic              set_stb_o;
   logic [7:0]        set_addr_o;
   set_word_t         set_data_o;

   logic [31:0] golden [0:n_col*max_ops-1];
   int          n_ops = 0;
   int          seed;
   int          op_errors;
   int          total_errors = 0;
   int          failed_ops = 0;
   int          assert_fails;
   int          pulse_count;
   set_word_t   pulse_word;
   logic [7:0]  pulse_addr;

   wb_core #(.gpio_w(gpio_w)) wb_core_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_valid_i(req_valid_i), .req_we_i(req_we_i), .req_adr_i(req_adr_i),
      .req_dat_i(req_dat_i), .req_sel_i(req_sel_i), .req_ready_o(req_ready_o),
      .rsp_valid_o(rsp_valid_o), .rsp_dat_o(rsp_dat_o), .rsp_err_o(rsp_err_o),
      .rsp_ready_i(rsp_ready_i),
      .switch_i(switch_i), .button_i(button_i), .led_o(led_o), .flags_o(flags_o),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o),
      .set_stb_o(set_stb_o), .set_addr_o(set_addr_o), .set_data_o(set_data_o)
   );

   always #4 wb_clk = ~wb_clk;

   // Settings strobes seen during the current operation
   always @(negedge wb_clk) begin
      if (set_stb_o) begin
         pulse_count++;
         pulse_word = set_data_o;
         pulse_addr = set_addr_o;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic problem(input string what);
      $display("Error at %0t ns: %s", $time, what);
      op_errors++;
   endtask

   task automatic check_rsp(input logic [wb_dw-1:0] got_dat, input logic got_err,
                            input logic [wb_dw-1:0] exp_dat, input logic exp_err);
      if (got_dat !== exp_dat) begin
         $display("Fail %0t ns: rsp_dat_o got %h expected %h", $time, got_dat, exp_dat);
         op_errors++;
      end
      if (got_err !== exp_err) begin
         $display("Fail %0t ns: rsp_err_o got %b expected %b", $time, got_err, exp_err);
         op_errors++;
      end
   endtask

   task automatic check_setting(input set_word_t got_word, input set_word_t exp_word,
                                input logic [7:0] got_adr, input logic [7:0] exp_adr);
      if (got_word.raw !== exp_word.raw) begin
         $display("Fail %0t ns: set_data_o got %h_%h expected %h_%h", $time,
                  got_word.halves.hi, got_word.halves.lo,
                  exp_word.halves.hi, exp_word.halves.lo);
         op_errors++;
      end
      if (got_adr !== exp_adr) begin
         $display("Fail %0t ns: set_addr_o got %h expected %h", $time, got_adr, exp_adr);
         op_errors++;
      end
   endtask

   task automatic check_pins(input logic [gpio_w-1:0] got_o, input logic [gpio_w-1:0] got_oe,
                             input logic [gpio_w-1:0] exp_o, input logic [gpio_w-1:0] exp_oe);
      if (got_o !== exp_o) begin
         $display("Fail %0t ns: gpio_o got %h expected %h", $time, got_o, exp_o);
         op_errors++;
      end
      if (got_oe !== exp_oe) begin
         $display("Fail %0t ns: gpio_oe_o got %h expected %h", $time, got_oe, exp_oe);
         op_errors++;
      end
   endtask

   task automatic check_board(input logic [2:0] got_led, input logic [3:0] got_flags,
                              input logic [2:0] exp_led, input logic [3:0] exp_flags);
      if (got_led !== exp_led) begin
         $display("Fail %0t ns: led_o got %h expected %h", $time, got_led, exp_led);
         op_errors++;
      end
      if (got_flags !== exp_flags) begin
         $display("Fail %0t ns: flags_o got %h expected %h", $time, got_flags, exp_flags);
         op_errors++;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One golden line drives stimulus and a host request then checks the results

   task automatic run_op(input int idx);
      logic [31:0]      kind;
      logic [31:0]      adr;
      logic [31:0]      stim;
      logic [31:0]      exp_a;
      logic [31:0]      exp_b;
      logic [wb_dw-1:0] held_dat;
      logic             held_err;
      int               lat;
      int               stall;
      kind  = golden[idx*n_col];
      adr   = golden[idx*n_col+1];
      stim  = golden[idx*n_col+3];
      exp_a = golden[idx*n_col+6];
      exp_b = golden[idx*n_col+7];
      op_errors   = 0;
      pulse_count = 0;
      @(posedge wb_clk);
      #1;
      gpio_i   = stim[gpio_w-1:0];
      switch_i = stim[23:16];
      button_i = stim[26:24];
      // Pins settle through the synchronizer first
      repeat (2) @(posedge wb_clk);
      #1;
      req_valid_i = 1'b1;
      req_we_i    = (kind != 0);
      req_adr_i   = adr[wb_aw-1:0];
      req_dat_i   = golden[idx*n_col+2][wb_dw-1:0];
      req_sel_i   = 2'b11;
      @(negedge wb_clk);
      while (!req_ready_o) @(negedge wb_clk);
      @(posedge wb_clk);
      #1;
      req_valid_i = 1'b0;
      lat = 1;
      @(negedge wb_clk);
      while (!rsp_valid_o && lat < 8) begin
         if (req_ready_o) problem("request port ready while a transaction is outstanding");
         @(negedge wb_clk);
         lat++;
      end
      if (!rsp_valid_o) begin
         problem("no response arrived");
      end else if (lat != 2) begin
         problem($sformatf("response came %0d cycles after acceptance, not 2", lat));
      end
      held_dat = rsp_dat_o;
      held_err = rsp_err_o;
      stall = {$random(seed)} % 4;
      repeat (stall) begin
         @(negedge wb_clk);
         if (!rsp_valid_o || rsp_dat_o !== held_dat || rsp_err_o !== held_err)
            problem("response was not held while the host stalled");
         if (req_ready_o) problem("request port ready while a response waits");
      end
      @(posedge wb_clk);
      #1;
      rsp_ready_i = 1'b1;
      @(negedge wb_clk);
      check_rsp(rsp_dat_o, rsp_err_o, golden[idx*n_col+4][wb_dw-1:0], golden[idx*n_col+5][0]);
      @(posedge wb_clk);
      #1;
      rsp_ready_i = 1'b0;
      @(negedge wb_clk);
      case (kind)
         2: check_board(led_o, flags_o, exp_a[2:0], exp_b[3:0]);
         3: check_pins(gpio_o, gpio_oe_o, exp_a[gpio_w-1:0], exp_b[gpio_w-1:0]);
         4: begin
            if (pulse_count != 1)
               problem($sformatf("expected one settings strobe, saw %0d", pulse_count));
            else
               check_setting(pulse_word, exp_b, pulse_addr, exp_a[7:0]);
         end
         default: ;
      endcase
      if (kind != 4 && pulse_count != 0) problem("settings strobe without a high-half write");
      $display("op %0d kind %0d adr %h done with %0d errors", idx, kind, adr[wb_aw-1:0],
               op_errors);
      total_errors += op_errors;
      if (op_errors != 0) failed_ops++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      seed         = 35;
      wb_clk       = 1'b0;
      wb_rst       = 1'b1;
      req_valid_i  = 1'b0;
      req_we_i     = 1'b0;
      req_adr_i    = '0;
      req_dat_i    = '0;
      req_sel_i    = '0;
      rsp_ready_i  = 1'b0;
      switch_i     = '0;
      button_i     = '0;
      gpio_i       = '0;
      $readmemh("tests/wb_core_golden.txt", golden);
      while (n_ops < max_ops && !$isunknown(golden[n_ops*n_col]) &&
             golden[n_ops*n_col] != 32'hF) begin
         n_ops++;
      end
      repeat (4) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      if (n_ops == 0) begin
         $display("Error: the golden file holds no operations");
         total_errors++;
      end
      for (int i = 0; i < n_ops; i++) begin
         run_op(i);
      end
      assert_fails = wb_core_inst.wb_host_bridge_inst.wb_core_assert_inst.n_fail;
      $display("%0d operations, %0d failed, %0d check errors, %0d assertion failures",
               n_ops, failed_ops, total_errors, assert_fails);
      if (total_errors == 0 && assert_fails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog allows twenty cycles per golden line plus reset
   initial begin
      wait (n_ops > 0);
      repeat ((n_ops + 1) * 20) @(posedge wb_clk);
      $display("Watchdog expired, the operations did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/wb_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_core_assert (
   input logic                          wb_clk,
   input logic                          wb_rst,
   input logic                          req_valid_i,
   input logic                          req_ready_i,
   input logic                          rsp_valid_i,
   input logic                          rsp_ready_i,
   input logic [wb_core_pkg::wb_dw-1:0] rsp_dat_i,
   input logic                          rsp_err_i,
   input logic                          cyc_i,
   input logic                          stb_i,
   input logic                          ack_i,
   input logic                          err_i
);

   int n_fail = 0;

   // Response held until the host takes it
   rsp_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_dat_i) && $stable(rsp_err_i))
      else begin
         $error("response changed before the host took it");
         n_fail++;
      end

   // Strobe sits inside cyc in the cycle after acceptance
   stb_in_cyc: assert property (@(posedge wb_clk) disable iff (wb_rst)
      stb_i |-> cyc_i && $past(req_valid_i && req_ready_i))
      else begin
         $error("stb high without cyc or not right after an accepted request");
         n_fail++;
      end

   one_answer: assert property (@(posedge wb_clk) disable iff (wb_rst) !(ack_i && err_i))
      else begin
         $error("ack and err high together");
         n_fail++;
      end

   // Response two edges after acceptance
   rsp_latency: assert property (@(posedge wb_clk) disable iff (wb_rst)
      req_valid_i && req_ready_i |=> !rsp_valid_i ##1 rsp_valid_i)
      else begin
         $error("response latency is not two cycles");
         n_fail++;
      end

endmodule

bind wb_host_bridge wb_core_assert wb_core_assert_inst (
   .wb_clk(wb_clk), .wb_rst(wb_rst),
   .req_valid_i(req_valid_i), .req_ready_i(req_ready_o),
   .rsp_valid_i(rsp_valid_o), .rsp_ready_i(rsp_ready_i),
   .rsp_dat_i(rsp_dat_o), .rsp_err_i(rsp_err_o),
   .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .ack_i(wb_ack_i), .err_i(wb_err_i)
);

`default_nettype wire

// ==== tests/wb_core_golden.txt ====
// kind adr dat stim exp_dat exp_err exp_a exp_b, all hex
// kind 0 read, 1 write, 2 board write (a led, b flags), 3 gpio write (a out, b oe),
// kind 4 setting high half (a set address, b set word), F end of list
// stim bits 15:0 drive gpio_i, 23:16 switch_i, 26:24 button_i
2 004 1236 00000000 0000 0 6    0
0 004 0000 00000000 1236 0 0    0
0 006 0000 05A50000 05A5 0 0    0
0 00A 0000 00000000 BEEF 0 0    0
2 008 000B 00000000 0000 0 6    B
3 200 FF0F 00000000 0000 0 0    FF0F
3 202 5A3C 00000000 0000 0 5A3C FF0F
0 200 0000 00000000 FF0F 0 0    0
0 204 0000 0000C3A1 C3A1 0 0    0
1 294 BEAD 00000000 0000 0 0    0
4 296 1234 00000000 0000 0 A5   1234BEAD
1 2C0 7777 00000000 0000 0 0    0
0 100 0000 00000000 0000 1 0    0
0 004 0000 00000000 1236 0 0    0
1 780 AAAA 00000000 0000 1 0    0
4 2C2 0F0F 00000000 0000 0 B0   0F0F7777
0 202 0000 00000000 5A3C 0 0    0
0 280 0000 00000000 0000 0 0    0
F 000 0000 00000000 0000 0 0    0

// ==== wb_core.f ====
design/wb_core_pkg.sv
design/wb_host_bridge.sv
design/wb_intercon.sv
design/board_regs.sv
design/settings_bus_16le.sv
design/gpio16.sv
design/wb_core.sv
tests/wb_core_assert.sv
tests/tb_wb_core.sv
